// File: verilog/fetch_pkg.sv
package fetch_pkg;

	// address and data widths.
	localparam int addr_width     = 32;
	localparam int inst_width     = 32;
	localparam int mem_data_width = 64;

	// response codes, bit 1 marks a cache miss.
	localparam int resp_width    = 2;
	localparam int resp_miss_bit = 1;

	// on-chip sram window, read around the cache.
	localparam logic [addr_width-1:0] sram_base  = 32'h0f000000;
	localparam logic [addr_width-1:0] sram_limit = 32'h0f002000;

	// direct-mapped cache, one word per line.
	localparam int icache_index_bits  = 4;
	localparam int icache_offset_bits = 2;
	localparam int icache_tag_bits    = 26;

	// performance counters.
	localparam int counter_width = 32;

endpackage

// File: verilog/ifu.sv
`timescale 1ns/1ps

module ifu (
	input  logic                                clock,
	input  logic                                reset,

	input  logic                                wb_valid,
	input  logic [fetch_pkg::addr_width-1:0]     pc,

	output logic [fetch_pkg::addr_width-1:0]     mem_araddr,
	output logic                                mem_arvalid,
	input  logic                                mem_arready,
	input  logic [fetch_pkg::mem_data_width-1:0] mem_rdata,
	input  logic [fetch_pkg::resp_width-1:0]     mem_rresp,
	input  logic                                mem_rvalid,
	output logic                                mem_rready,

	output logic [fetch_pkg::addr_width-1:0]     icache_araddr,
	output logic                                icache_arvalid,
	input  logic                                icache_arready,
	input  logic [fetch_pkg::inst_width-1:0]     icache_rdata,
	input  logic [fetch_pkg::resp_width-1:0]     icache_rresp,
	input  logic                                icache_rvalid,
	output logic                                icache_rready,

	output logic [fetch_pkg::addr_width-1:0]     icache_awaddr,
	output logic                                icache_awvalid,
	input  logic                                icache_awready,
	output logic [fetch_pkg::inst_width-1:0]     icache_wdata,
	output logic                                icache_wvalid,
	input  logic                                icache_wready,
	input  logic [fetch_pkg::resp_width-1:0]     icache_bresp,
	input  logic                                icache_bvalid,
	output logic                                icache_bready,

	output logic [fetch_pkg::inst_width-1:0]     inst,
	output logic                                idu_valid,
	output logic                                fetch_busy
);

	import fetch_pkg::*;

	logic                  fetch_start;
	logic                  pc_in_sram;
	logic                  mem_rd_fire;
	logic                  mem_rd_ok;
	logic                  cache_rd_fire;
	logic                  cache_hit;
	logic                  cache_miss;
	logic                  refill_start;
	logic                  refill_ack;
	logic                  fetch_done;
	logic [inst_width-1:0] mem_inst;

	// decode has no back-pressure so responses are always taken.
	assign mem_rready    = 1'b1;
	assign icache_rready = 1'b1;
	assign icache_bready = 1'b1;

	assign mem_araddr    = pc;
	assign icache_araddr = pc;
	assign icache_awaddr = pc;
	assign icache_wdata  = inst;

	assign pc_in_sram = (pc >= sram_base) && (pc < sram_limit);

	assign mem_rd_fire   = mem_rvalid & mem_rready;
	assign mem_rd_ok     = mem_rresp == '0;
	assign cache_rd_fire = icache_rvalid & icache_rready;
	assign cache_hit     = cache_rd_fire & ~icache_rresp[resp_miss_bit];
	assign cache_miss    = cache_rd_fire & icache_rresp[resp_miss_bit];

	// a faulted memory word is handed to decode but never cached.
	assign refill_start = mem_rd_fire & ~pc_in_sram & mem_rd_ok;
	// the write response only ends the fetch since the word is already latched.
	assign refill_ack   = icache_bvalid & icache_bready;

	assign fetch_done = cache_hit | refill_ack |
		(mem_rd_fire & (pc_in_sram | ~mem_rd_ok));

	// sram reads return a doubleword and pc bit 2 picks the half.
	assign mem_inst = (pc_in_sram && pc[2]) ? mem_rdata[inst_width +: inst_width]
		: mem_rdata[inst_width-1:0];

	// one fetch of pc is started straight out of reset.
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_start <= 1'b1;
		end else begin
			fetch_start <= wb_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			icache_arvalid <= 1'b0;
		end else if (icache_arvalid) begin
			icache_arvalid <= ~icache_arready;
		end else begin
			icache_arvalid <= fetch_start & ~pc_in_sram;
		end
	end

	// direct sram read or the memory read after a cache miss.
	always_ff @(posedge clock) begin
		if (reset) begin
			mem_arvalid <= 1'b0;
		end else if (mem_arvalid) begin
			mem_arvalid <= ~mem_arready;
		end else begin
			mem_arvalid <= cache_miss | (fetch_start & pc_in_sram);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			icache_awvalid <= 1'b0;
			icache_wvalid  <= 1'b0;
		end else begin
			if (icache_awvalid) begin
				icache_awvalid <= ~icache_awready;
			end else begin
				icache_awvalid <= refill_start;
			end
			if (icache_wvalid) begin
				icache_wvalid <= ~icache_wready;
			end else begin
				icache_wvalid <= refill_start;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (mem_rd_fire) begin
			inst <= mem_inst;
		end else if (cache_hit) begin
			inst <= icache_rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			idu_valid  <= 1'b0;
			fetch_busy <= 1'b0;
		end else begin
			idu_valid <= fetch_done;
			if (fetch_start) begin
				fetch_busy <= 1'b1;
			end else if (fetch_done) begin
				fetch_busy <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/icache.sv
`timescale 1ns/1ps

module icache (
	input  logic                            clock,
	input  logic                            reset,

	input  logic [fetch_pkg::addr_width-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic [fetch_pkg::inst_width-1:0] rdata,
	output logic [fetch_pkg::resp_width-1:0] rresp,
	output logic                            rvalid,
	input  logic                            rready,

	input  logic [fetch_pkg::addr_width-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [fetch_pkg::inst_width-1:0] wdata,
	input  logic                            wvalid,
	output logic                            wready,
	output logic [fetch_pkg::resp_width-1:0] bresp,
	output logic                            bvalid,
	input  logic                            bready,

	output logic                            hit_strobe,
	output logic                            miss_strobe
);

	import fetch_pkg::*;

	logic [(1 << icache_index_bits)-1:0] line_valid;
	logic [icache_tag_bits-1:0]          tag_mem  [1 << icache_index_bits];
	logic [inst_width-1:0]               data_mem [1 << icache_index_bits];

	logic [icache_index_bits-1:0] rd_index;
	logic [icache_tag_bits-1:0]   rd_tag;
	logic                         rd_hit;
	logic                         ar_fire;

	logic                         aw_fire;
	logic                         w_fire;
	logic                         aw_taken;
	logic                         w_taken;
	logic                         aw_done;
	logic                         w_done;
	logic                         wr_commit;
	logic [addr_width-1:0]        aw_addr_q;
	logic [inst_width-1:0]        w_data_q;
	logic [addr_width-1:0]        wr_addr;
	logic [inst_width-1:0]        wr_data;
	logic [icache_index_bits-1:0] wr_index;
	logic [icache_tag_bits-1:0]   wr_tag;

	// read port.
	assign rd_index = araddr[icache_offset_bits +: icache_index_bits];
	assign rd_tag   = araddr[addr_width-1 -: icache_tag_bits];
	assign rd_hit   = line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);

	// idle whenever no read response is waiting.
	assign arready = ~rvalid;
	assign ar_fire = arvalid & arready;

	always_ff @(posedge clock) begin
		if (reset) begin
			rvalid      <= 1'b0;
			hit_strobe  <= 1'b0;
			miss_strobe <= 1'b0;
		end else begin
			if (ar_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			hit_strobe  <= ar_fire & rd_hit;
			miss_strobe <= ar_fire & ~rd_hit;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rdata                <= data_mem[rd_index];
			rresp                <= '0;
			rresp[resp_miss_bit] <= ~rd_hit;
		end
	end

	// write port, address and data taken in any order.
	assign awready = ~aw_taken & ~bvalid;
	assign wready  = ~w_taken & ~bvalid;
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;

	assign aw_done   = aw_taken | aw_fire;
	assign w_done    = w_taken | w_fire;
	assign wr_commit = aw_done & w_done & ~bvalid;

	assign wr_addr  = aw_taken ? aw_addr_q : awaddr;
	assign wr_data  = w_taken ? w_data_q : wdata;
	assign wr_index = wr_addr[icache_offset_bits +: icache_index_bits];
	assign wr_tag   = wr_addr[addr_width-1 -: icache_tag_bits];

	// refills always land.
	assign bresp = '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_taken <= 1'b0;
			w_taken  <= 1'b0;
			bvalid   <= 1'b0;
		end else begin
			if (wr_commit) begin
				aw_taken <= 1'b0;
				w_taken  <= 1'b0;
				bvalid   <= 1'b1;
			end else begin
				aw_taken <= aw_done;
				w_taken  <= w_done;
				if (bready) begin
					bvalid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			aw_addr_q <= awaddr;
		end
		if (w_fire) begin
			w_data_q <= wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (wr_commit) begin
			line_valid[wr_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_commit) begin
			tag_mem[wr_index]  <= wr_tag;
			data_mem[wr_index] <= wr_data;
		end
	end

endmodule

// File: verilog/fetch_perf.sv
`timescale 1ns/1ps

module fetch_perf (
	input  logic                               clock,
	input  logic                               reset,

	input  logic                               fetch_busy,
	input  logic                               hit_strobe,
	input  logic                               miss_strobe,

	output logic [fetch_pkg::counter_width-1:0] busy_cycles,
	output logic [fetch_pkg::counter_width-1:0] icache_hits,
	output logic [fetch_pkg::counter_width-1:0] icache_misses
);

	import fetch_pkg::*;

	logic [2:0]               count_inc;
	logic [counter_width-1:0] count [3];

	assign count_inc = {miss_strobe, hit_strobe, fetch_busy};

	// each counter sticks at its maximum instead of wrapping.
	for (genvar i = 0; i < 3; i++) begin : g_counter
		always_ff @(posedge clock) begin
			if (reset) begin
				count[i] <= '0;
			end else if (count_inc[i] && !(&count[i])) begin
				count[i] <= count[i] + 1'b1;
			end
		end
	end

	assign busy_cycles   = count[0];
	assign icache_hits   = count[1];
	assign icache_misses = count[2];

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic                                clock,
	input  logic                                reset,

	input  logic                                wb_valid,
	input  logic [fetch_pkg::addr_width-1:0]     pc,
	output logic [fetch_pkg::inst_width-1:0]     inst,
	output logic                                idu_valid,

	output logic [fetch_pkg::addr_width-1:0]     mem_araddr,
	output logic                                mem_arvalid,
	input  logic                                mem_arready,
	input  logic [fetch_pkg::mem_data_width-1:0] mem_rdata,
	input  logic [fetch_pkg::resp_width-1:0]     mem_rresp,
	input  logic                                mem_rvalid,
	output logic                                mem_rready,

	output logic [fetch_pkg::counter_width-1:0]  busy_cycles,
	output logic [fetch_pkg::counter_width-1:0]  icache_hits,
	output logic [fetch_pkg::counter_width-1:0]  icache_misses
);

	import fetch_pkg::*;

	logic [addr_width-1:0] icache_araddr;
	logic                  icache_arvalid;
	logic                  icache_arready;
	logic [inst_width-1:0] icache_rdata;
	logic [resp_width-1:0] icache_rresp;
	logic                  icache_rvalid;
	logic                  icache_rready;
	logic [addr_width-1:0] icache_awaddr;
	logic                  icache_awvalid;
	logic                  icache_awready;
	logic [inst_width-1:0] icache_wdata;
	logic                  icache_wvalid;
	logic                  icache_wready;
	logic [resp_width-1:0] icache_bresp;
	logic                  icache_bvalid;
	logic                  icache_bready;
	logic                  fetch_busy;
	logic                  hit_strobe;
	logic                  miss_strobe;

	ifu u_ifu (
		.clock          (clock),
		.reset          (reset),
		.wb_valid       (wb_valid),
		.pc             (pc),
		.mem_araddr     (mem_araddr),
		.mem_arvalid    (mem_arvalid),
		.mem_arready    (mem_arready),
		.mem_rdata      (mem_rdata),
		.mem_rresp      (mem_rresp),
		.mem_rvalid     (mem_rvalid),
		.mem_rready     (mem_rready),
		.icache_araddr  (icache_araddr),
		.icache_arvalid (icache_arvalid),
		.icache_arready (icache_arready),
		.icache_rdata   (icache_rdata),
		.icache_rresp   (icache_rresp),
		.icache_rvalid  (icache_rvalid),
		.icache_rready  (icache_rready),
		.icache_awaddr  (icache_awaddr),
		.icache_awvalid (icache_awvalid),
		.icache_awready (icache_awready),
		.icache_wdata   (icache_wdata),
		.icache_wvalid  (icache_wvalid),
		.icache_wready  (icache_wready),
		.icache_bresp   (icache_bresp),
		.icache_bvalid  (icache_bvalid),
		.icache_bready  (icache_bready),
		.inst           (inst),
		.idu_valid      (idu_valid),
		.fetch_busy     (fetch_busy)
	);

	icache u_icache (
		.clock       (clock),
		.reset       (reset),
		.araddr      (icache_araddr),
		.arvalid     (icache_arvalid),
		.arready     (icache_arready),
		.rdata       (icache_rdata),
		.rresp       (icache_rresp),
		.rvalid      (icache_rvalid),
		.rready      (icache_rready),
		.awaddr      (icache_awaddr),
		.awvalid     (icache_awvalid),
		.awready     (icache_awready),
		.wdata       (icache_wdata),
		.wvalid      (icache_wvalid),
		.wready      (icache_wready),
		.bresp       (icache_bresp),
		.bvalid      (icache_bvalid),
		.bready      (icache_bready),
		.hit_strobe  (hit_strobe),
		.miss_strobe (miss_strobe)
	);

	fetch_perf u_fetch_perf (
		.clock         (clock),
		.reset         (reset),
		.fetch_busy    (fetch_busy),
		.hit_strobe    (hit_strobe),
		.miss_strobe   (miss_strobe),
		.busy_cycles   (busy_cycles),
		.icache_hits   (icache_hits),
		.icache_misses (icache_misses)
	);

endmodule

// File: tests/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [fetch_pkg::addr_width-1:0]     araddr,
	input  logic                                arvalid,
	output logic                                arready,
	output logic [fetch_pkg::mem_data_width-1:0] rdata,
	output logic [fetch_pkg::resp_width-1:0]     rresp,
	output logic                                rvalid,
	input  logic                                rready
);

	import fetch_pkg::*;

	localparam logic [31:0] lfsr_seed = 32'h9523dc66;
	localparam logic [31:0] lfsr_taps = 32'ha3000000;

	logic [31:0] lfsr_state;

	function automatic logic [31:0] mem_word(input logic [31:0] x);
		return {x[24:0], x[31:25]} ^ 32'hc3a5_1e69;
	endfunction

	// two lfsr bits give a delay of 0 to 3 cycles.
	function automatic int draw_delay();
		logic [1:0] value;
		value = '0;
		for (int i = 0; i < 2; i++) begin
			value = {value[0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
		end
		return int'(value);
	endfunction

	function automatic logic [mem_data_width-1:0] read_data(input logic [addr_width-1:0] addr);
		if (addr >= sram_base && addr < sram_limit) begin
			return {mem_word(addr | 32'h4), mem_word(addr & ~32'h4)};
		end
		// the high half is never used outside the sram window.
		return {~mem_word(addr), mem_word(addr)};
	endfunction

	initial begin
		logic [addr_width-1:0] addr;
		int                    delay;
		logic                  taken;
		lfsr_state = lfsr_seed;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = '0;
		@(posedge clock);
		#1;
		forever begin
			if (!reset && arvalid) begin
				delay = draw_delay();
				repeat (delay) begin
					@(posedge clock);
					#1;
				end
				arready = 1'b1;
				addr = araddr;
				@(posedge clock);
				#1;
				arready = 1'b0;
				delay = draw_delay();
				repeat (delay) begin
					@(posedge clock);
					#1;
				end
				rvalid = 1'b1;
				rdata = read_data(addr);
				taken = 1'b0;
				while (!taken) begin
					taken = rready;
					@(posedge clock);
					#1;
				end
				rvalid = 1'b0;
				rdata = '0;
			end else begin
				@(posedge clock);
				#1;
			end
		end
	end

endmodule

// File: tests/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

	import fetch_pkg::*;

	localparam int          num_fetches    = 300;
	localparam int          timeout_cycles = num_fetches * 20;
	localparam int          reset_cycles   = 10;
	localparam logic [31:0] lfsr_seed      = 32'h9523dc66;
	localparam logic [31:0] lfsr_taps      = 32'ha3000000;

	logic                       clock;
	logic                       reset;
	logic                       wb_valid;
	logic [addr_width-1:0]      pc;
	logic [inst_width-1:0]      inst;
	logic                       idu_valid;
	logic [addr_width-1:0]      mem_araddr;
	logic                       mem_arvalid;
	logic                       mem_arready;
	logic [mem_data_width-1:0]  mem_rdata;
	logic [resp_width-1:0]      mem_rresp;
	logic                       mem_rvalid;
	logic                       mem_rready;
	logic [counter_width-1:0]   busy_cycles;
	logic [counter_width-1:0]   icache_hits;
	logic [counter_width-1:0]   icache_misses;

	logic [31:0]                lfsr_state;
	logic [addr_width-1:0]      pc_pool [16];
	logic                       model_valid [1 << icache_index_bits];
	logic [icache_tag_bits-1:0] model_tag [1 << icache_index_bits];
	logic [counter_width-1:0]   exp_hits;
	logic [counter_width-1:0]   exp_misses;
	logic [counter_width-1:0]   busy_seen;
	logic [counter_width-1:0]   busy_before;
	logic [addr_width-1:0]      last_araddr;
	logic                       last_arvalid;
	logic                       last_arready;
	logic                       last_idu;
	logic                       fetch_open;
	int                         mem_reads;
	int                         idu_pulses;
	int                         cycle_count;

	fetch_top u_dut (.*);

	tb_memory u_mem (
		.clock   (clock),
		.reset   (reset),
		.araddr  (mem_araddr),
		.arvalid (mem_arvalid),
		.arready (mem_arready),
		.rdata   (mem_rdata),
		.rresp   (mem_rresp),
		.rvalid  (mem_rvalid),
		.rready  (mem_rready)
	);

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
		end
		return value;
	endfunction

	function automatic logic [addr_width-1:0] pick_pc();
		logic [31:0] r;
		r = random_bits(4);
		return pc_pool[r[3:0]];
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] x);
		return {x[24:0], x[31:25]} ^ 32'hc3a5_1e69;
	endfunction

	task automatic report_failure(input string what);
		$display("** Error at time %0t: %s", $time, what);
		$display("Result: FAILED");
		$fatal(1, "fetch test stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		report_failure($sformatf("%s = 0x%08h, expected 0x%08h", name, got, expected));
	endtask

	// bus protocol and pulse checks once per cycle at the falling edge.
	task automatic sample_cycle();
		@(negedge clock);
		cycle_count++;
		assert (cycle_count <= timeout_cycles)
			else report_failure("timeout, the fetch stream did not finish");
		if (last_arvalid && !last_arready) begin
			assert (mem_arvalid) else report_failure("mem_arvalid dropped before mem_arready");
			assert (mem_araddr == last_araddr)
				else report_mismatch("mem_araddr", mem_araddr, last_araddr);
		end
		assert (busy_cycles >= busy_seen)
			else report_mismatch("busy_cycles", busy_cycles, busy_seen);
		if (mem_arvalid && mem_arready) begin
			mem_reads++;
		end
		if (idu_valid) begin
			assert (!last_idu) else report_failure("idu_valid stayed high for two cycles");
			assert (fetch_open) else report_failure("idu_valid pulsed with no fetch in flight");
			idu_pulses++;
		end
		last_arvalid = mem_arvalid;
		last_arready = mem_arready;
		last_araddr = mem_araddr;
		last_idu = idu_valid;
		busy_seen = busy_cycles;
	endtask

	task automatic start_fetch();
		@(posedge clock);
		#1;
		pc = pick_pc();
		wb_valid = 1'b1;
		mem_reads = 0;
		fetch_open = 1'b1;
		sample_cycle();
		@(posedge clock);
		#1;
		wb_valid = 1'b0;
	endtask

	// the reference cache model decides hit or miss for each pc.
	task automatic check_fetch();
		logic                         in_sram;
		logic [icache_index_bits-1:0] index;
		logic [icache_tag_bits-1:0]   tag;
		int                           exp_reads;
		in_sram = (pc >= sram_base) && (pc < sram_limit);
		index = pc[icache_offset_bits +: icache_index_bits];
		tag = pc[addr_width-1 -: icache_tag_bits];
		exp_reads = 1;
		if (!in_sram && model_valid[index] && model_tag[index] == tag) begin
			exp_hits++;
			exp_reads = 0;
		end else if (!in_sram) begin
			exp_misses++;
			model_valid[index] = 1'b1;
			model_tag[index] = tag;
		end
		assert (inst == mem_word(pc)) else report_mismatch("inst", inst, mem_word(pc));
		assert (icache_hits == exp_hits)
			else report_mismatch("icache_hits", icache_hits, exp_hits);
		assert (icache_misses == exp_misses)
			else report_mismatch("icache_misses", icache_misses, exp_misses);
		assert (mem_reads == exp_reads)
			else report_mismatch("memory reads", mem_reads, exp_reads);
		assert (busy_cycles > busy_before)
			else report_mismatch("busy_cycles", busy_cycles, busy_before + 1);
		busy_before = busy_cycles;
		fetch_open = 1'b0;
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		lfsr_state = lfsr_seed;
		reset = 1'b1;
		wb_valid = 1'b0;
		// sram words, repeated lines and lines that share an index.
		pc_pool = '{32'h0f000000, 32'h0f000004, 32'h0f000ff8, 32'h0f001ffc,
			32'h80000000, 32'h80000040, 32'h80001000, 32'h80000004,
			32'h8000003c, 32'h8000107c, 32'h20000010, 32'h20000050,
			32'h00000020, 32'h0effffe0, 32'h0f002000, 32'h80000008};
		for (int i = 0; i < (1 << icache_index_bits); i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
		end
		exp_hits = '0;
		exp_misses = '0;
		busy_seen = '0;
		busy_before = '0;
		last_araddr = '0;
		last_arvalid = 1'b0;
		last_arready = 1'b0;
		last_idu = 1'b0;
		mem_reads = 0;
		idu_pulses = 0;
		cycle_count = 0;
		// the first fetch starts by itself when reset is released.
		fetch_open = 1'b1;
		pc = pick_pc();
		repeat (reset_cycles) @(posedge clock);
		#1;
		reset = 1'b0;
		sample_cycle();
		assert (busy_cycles == '0) else report_mismatch("busy_cycles", busy_cycles, 0);
		assert (icache_hits == '0) else report_mismatch("icache_hits", icache_hits, 0);
		assert (icache_misses == '0) else report_mismatch("icache_misses", icache_misses, 0);
		for (int n = 0; n < num_fetches; n++) begin
			if (n > 0) begin
				start_fetch();
			end
			sample_cycle();
			while (!idu_valid) begin
				sample_cycle();
			end
			check_fetch();
			assert (idu_pulses == n + 1)
				else report_mismatch("idu_valid pulses", idu_pulses, n + 1);
		end
		// a stray idu_valid pulse here has no fetch in flight.
		repeat (4) sample_cycle();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: src.f
verilog/fetch_pkg.sv
verilog/ifu.sv
verilog/icache.sv
verilog/fetch_perf.sv
verilog/fetch_top.sv
tests/tb_memory.sv
tests/tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fetch -o tb_fetch -f src.f &&
	{ ./obj_dir/tb_fetch > sim.log 2>&1 || true; } &&
	cat sim.log &&
	grep -qx "Result: PASSED" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
